// File: design/arq_macros.svh
`ifndef ARQ_MACROS_SVH
`define ARQ_MACROS_SVH

// Buffer slots, one always left unused
`define ARQ_DEPTH 8

// Field widths
`define ARQ_TAG_W 8
`define ARQ_PAYLOAD_W 16
`define ARQ_AGE_W 8

// Age saturates here
`define ARQ_AGE_MAX 255

// APB register map
`define ARQ_ADDR_PUSH 12'h000
`define ARQ_ADDR_CFG 12'h004
`define ARQ_ADDR_STATUS 12'h008

`endif

// File: design/arq_apb_pkg.sv
`default_nettype none

`include "arq_macros.svh"

package arq_apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // Write word as seen at the push address
    typedef struct packed {
        logic [32-`ARQ_TAG_W-`ARQ_PAYLOAD_W-1:0] unused;
        logic [`ARQ_TAG_W-1:0]                   tag;
        logic [`ARQ_PAYLOAD_W-1:0]               payload;
    } apb_wdata_push_t;

    // Write word as seen at the configuration address
    typedef struct packed {
        logic [32-`ARQ_AGE_W-2:0] unused;
        logic [`ARQ_AGE_W-1:0]    threshold;
        logic                     aging_en;
    } apb_wdata_cfg_t;

    typedef union packed {
        apb_wdata_push_t push_view;
        apb_wdata_cfg_t  cfg_view;
    } apb_wdata_u;

    typedef struct packed {
        logic                  aging_en;
        logic [`ARQ_AGE_W-1:0] threshold;
    } arq_cfg_t;

endpackage

`default_nettype wire

// File: design/arq_entry_pkg.sv
`default_nettype none

`include "arq_macros.svh"

package arq_entry_pkg;

    // What the host asks for
    typedef struct packed {
        logic [`ARQ_TAG_W-1:0]     tag;
        logic [`ARQ_PAYLOAD_W-1:0] payload;
    } arq_req_t;

    // Stored word, age in the low bits
    typedef struct packed {
        arq_req_t              req;
        logic [`ARQ_AGE_W-1:0] age;
    } arq_entry_t;

    // Dispatched word
    typedef struct packed {
        arq_entry_t entry;
        logic       urgent;
    } arq_item_t;

endpackage

`default_nettype wire

// File: design/apb_request_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "arq_macros.svh"

module apb_request_port (
    input  logic                    clk,
    input  logic                    rst,
    input  arq_apb_pkg::apb_req_t   apb_req,
    output arq_apb_pkg::apb_rsp_t   apb_rsp,
    input  logic                    full,
    input  logic                    empty,
    output logic                    push_valid,
    output arq_entry_pkg::arq_req_t push_req,
    output arq_apb_pkg::arq_cfg_t   cfg
);

    logic                    access;
    logic                    hit_push;
    logic                    hit_cfg;
    logic                    hit_status;
    logic                    refused;
    logic [31:0]             rdata;
    arq_apb_pkg::apb_wdata_u wdata;

    assign access     = apb_req.psel & apb_req.penable;
    assign hit_push   = apb_req.paddr == `ARQ_ADDR_PUSH;
    assign hit_cfg    = apb_req.paddr == `ARQ_ADDR_CFG;
    assign hit_status = apb_req.paddr == `ARQ_ADDR_STATUS;
    assign wdata      = apb_req.pwdata;

    // Push goes out during the access cycle only
    assign push_valid       = access & apb_req.pwrite & hit_push & ~full;
    assign push_req.tag     = wdata.push_view.tag;
    assign push_req.payload = wdata.push_view.payload;

    // Push is write only, status is read only
    always_comb begin
        if (apb_req.pwrite) begin
            refused = hit_push ? full : ~hit_cfg;
        end else begin
            refused = ~(hit_cfg | hit_status);
        end
    end

    always_comb begin
        rdata = '0;
        if (!apb_req.pwrite) begin
            if (hit_cfg) begin
                rdata = 32'({cfg.threshold, cfg.aging_en});
            end else if (hit_status) begin
                rdata = {30'b0, full, empty};
            end
        end
    end

    assign apb_rsp.pready  = access;
    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pslverr = access & refused;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (access && apb_req.pwrite && hit_cfg) begin
            cfg.aging_en  <= wdata.cfg_view.aging_en;
            cfg.threshold <= wdata.cfg_view.threshold;
        end
    end

    // One push per accepted transfer
    a_push_one_cycle: assert property (
        @(posedge clk) disable iff (rst) push_valid |=> !push_valid
    );

endmodule

`default_nettype wire

// File: design/age_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "arq_macros.svh"

module age_queue #(
    parameter int DEPTH = `ARQ_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           push_valid,
    input  arq_entry_pkg::arq_req_t        push_req,
    input  logic                           pop,
    output arq_entry_pkg::arq_entry_t      head,
    output logic                           full,
    output logic                           empty,
    output logic                           push_fire,
    output logic [DEPTH-1:0]               valid_mask,
    output logic [DEPTH*`ARQ_AGE_W-1:0]    old_ages,
    input  logic [DEPTH*`ARQ_AGE_W-1:0]    new_ages,
    input  logic [DEPTH-1:0]               modify_mask
);

    localparam int AW = `ARQ_AGE_W;

    arq_entry_pkg::arq_entry_t mem [DEPTH];
    logic [DEPTH-1:0]          wr_ptr;
    logic [DEPTH-1:0]          rd_ptr;
    logic [DEPTH-1:0]          wr_ptr_nxt;
    logic [DEPTH-1:0]          rd_ptr_nxt;
    logic [DEPTH-1:0]          span;

    assign wr_ptr_nxt = {wr_ptr[DEPTH-2:0], wr_ptr[DEPTH-1]};
    assign rd_ptr_nxt = {rd_ptr[DEPTH-2:0], rd_ptr[DEPTH-1]};

    assign empty     = wr_ptr == rd_ptr;
    assign full      = wr_ptr_nxt == rd_ptr;
    assign push_fire = push_valid & ~full;

    // Slots from read up to write, complemented when the write side has wrapped
    assign span       = (wr_ptr - 1'b1) ^ (rd_ptr - 1'b1);
    assign valid_mask = (wr_ptr >= rd_ptr) ? span : ~span;

    always_comb begin
        head = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (rd_ptr[i]) begin
                head = mem[i];
            end
        end
    end

    for (genvar g = 0; g < DEPTH; g++) begin : g_ages
        assign old_ages[g*AW +: AW] = mem[g].age;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push_fire && wr_ptr[i]) begin
                mem[i].req <= push_req;
                mem[i].age <= '0;
            end else if (modify_mask[i]) begin
                mem[i].age <= new_ages[i*AW +: AW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= DEPTH'(1);
            rd_ptr <= DEPTH'(1);
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr_nxt;
            end
        end
    end

    a_ptrs_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(wr_ptr) && $onehot(rd_ptr)
    );

    // Dispatch stage only pops what is there
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) !(pop && empty)
    );

endmodule

`default_nettype wire

// File: design/age_tracker.sv
`timescale 1ns/100ps
`default_nettype none

`include "arq_macros.svh"

module age_tracker (
    input  logic [`ARQ_DEPTH*`ARQ_AGE_W-1:0] old_ages,
    input  logic [`ARQ_DEPTH-1:0]            valid_mask,
    input  logic                             push_fire,
    input  arq_apb_pkg::arq_cfg_t            cfg,
    output logic [`ARQ_DEPTH*`ARQ_AGE_W-1:0] new_ages,
    output logic [`ARQ_DEPTH-1:0]            modify_mask
);

    localparam int AW = `ARQ_AGE_W;

    logic bump;

    // Every accepted push ages whatever is already waiting
    assign bump = push_fire & cfg.aging_en;

    always_comb begin
        new_ages    = old_ages;
        modify_mask = '0;
        for (int i = 0; i < `ARQ_DEPTH; i++) begin
            if (bump && valid_mask[i] && old_ages[i*AW +: AW] < AW'(`ARQ_AGE_MAX)) begin
                modify_mask[i]      = 1'b1;
                new_ages[i*AW +: AW] = old_ages[i*AW +: AW] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dispatch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  arq_entry_pkg::arq_entry_t head,
    input  logic                      empty,
    input  arq_apb_pkg::arq_cfg_t     cfg,
    output logic                      pop,
    output logic                      out_valid,
    output arq_entry_pkg::arq_item_t  out_item,
    input  logic                      out_ready
);

    logic load;

    // Register free or draining this cycle
    assign load = !empty && (!out_valid || out_ready);
    assign pop  = load;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Age is frozen from here on
    always_ff @(posedge clk) begin
        if (load) begin
            out_item.entry  <= head;
            out_item.urgent <= head.age >= cfg.threshold;
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_item)
    );

endmodule

`default_nettype wire

// File: design/aging_request_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "arq_macros.svh"

module aging_request_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  arq_apb_pkg::apb_req_t    apb_req,
    output arq_apb_pkg::apb_rsp_t    apb_rsp,
    output logic                     out_valid,
    output arq_entry_pkg::arq_item_t out_item,
    input  logic                     out_ready
);

    logic                              full;
    logic                              empty;
    logic                              push_valid;
    logic                              push_fire;
    logic                              pop;
    arq_entry_pkg::arq_req_t           push_req;
    arq_entry_pkg::arq_entry_t         head;
    arq_apb_pkg::arq_cfg_t             cfg;
    logic [`ARQ_DEPTH-1:0]             valid_mask;
    logic [`ARQ_DEPTH-1:0]             modify_mask;
    logic [`ARQ_DEPTH*`ARQ_AGE_W-1:0]  old_ages;
    logic [`ARQ_DEPTH*`ARQ_AGE_W-1:0]  new_ages;

    apb_request_port u_port (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .full       (full),
        .empty      (empty),
        .push_valid (push_valid),
        .push_req   (push_req),
        .cfg        (cfg)
    );

    age_queue #(
        .DEPTH (`ARQ_DEPTH)
    ) u_queue (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (push_valid),
        .push_req    (push_req),
        .pop         (pop),
        .head        (head),
        .full        (full),
        .empty       (empty),
        .push_fire   (push_fire),
        .valid_mask  (valid_mask),
        .old_ages    (old_ages),
        .new_ages    (new_ages),
        .modify_mask (modify_mask)
    );

    age_tracker u_tracker (
        .old_ages    (old_ages),
        .valid_mask  (valid_mask),
        .push_fire   (push_fire),
        .cfg         (cfg),
        .new_ages    (new_ages),
        .modify_mask (modify_mask)
    );

    dispatch_stage u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .empty     (empty),
        .cfg       (cfg),
        .pop       (pop),
        .out_valid (out_valid),
        .out_item  (out_item),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tb/tb_aging_request_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "arq_macros.svh"

module tb_aging_request_queue;

    localparam int CLK_PERIOD = 10;
    // One entry in the dispatch register plus the usable buffer slots
    localparam int MODEL_CAPACITY = 1 + (`ARQ_DEPTH - 1);
    localparam int TRANSFERS = 80;
    localparam int WATCHDOG_CYCLES = TRANSFERS * 20 + 100;
    localparam int WAIT_LIMIT = 16;

    logic                     clk = 1'b0;
    logic                     rst;
    arq_apb_pkg::apb_req_t    apb_req;
    arq_apb_pkg::apb_rsp_t    apb_rsp;
    logic                     out_valid;
    arq_entry_pkg::arq_item_t out_item;
    logic                     out_ready;

    int          errors = 0;
    int          checks = 0;
    string       test_name = "none";
    logic [31:0] lfsr = 32'ha35f;
    logic [7:0]  next_tag = 8'h01;

    // Model queue whose front is the entry held by the dispatch register
    arq_entry_pkg::arq_req_t model_req[$];
    int unsigned             model_age[$];
    logic                    model_aging_en = 1'b0;
    logic [`ARQ_AGE_W-1:0]   model_threshold = '0;

    aging_request_queue UUT (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .out_valid (out_valid),
        .out_item  (out_item),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] predicted_status();
        logic full;
        logic empty;
        full  = model_req.size() == MODEL_CAPACITY;
        empty = model_req.size() <= 1;
        return {30'b0, full, empty};
    endfunction

    task automatic compare_values(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apb_rsp.pready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!apb_rsp.pready) begin
            errors++;
            $display("APB transfer to address %h never got pready", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // Stream sink that takes one item
    task automatic pop_item(output arq_entry_pkg::arq_item_t item, output logic got);
        int waited;
        @(posedge clk);
        out_ready <= 1'b1;
        waited = 0;
        got = 1'b0;
        while (!got && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (out_valid) begin
                got  = 1'b1;
                item = out_item;
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
        if (!got) begin
            errors++;
            $display("Stream sink in %s saw no item on the output", test_name);
        end
    endtask

    task automatic set_config(input logic aging_en, input logic [`ARQ_AGE_W-1:0] threshold);
        logic err;
        apb_write(`ARQ_ADDR_CFG, 32'({threshold, aging_en}), err);
        compare_values("config write pslverr", 1'b0, err);
        model_aging_en  = aging_en;
        model_threshold = threshold;
    endtask

    task automatic push_request(input logic [7:0] tag, input logic [15:0] payload);
        logic                    err;
        logic                    refused;
        arq_entry_pkg::arq_req_t req;
        refused     = model_req.size() == MODEL_CAPACITY;
        req.tag     = tag;
        req.payload = payload;
        apb_write(`ARQ_ADDR_PUSH, {8'h00, tag, payload}, err);
        compare_values("push pslverr", refused, err);
        if (!refused) begin
            // Entries still waiting in the buffer grow older
            for (int i = 1; i < model_req.size(); i++) begin
                if (model_aging_en && model_age[i] < `ARQ_AGE_MAX) begin
                    model_age[i]++;
                end
            end
            model_req.push_back(req);
            model_age.push_back(0);
        end
    endtask

    task automatic push_random(input int n);
        for (int i = 0; i < n; i++) begin
            push_request(next_tag, 16'(random_bits(16)));
            next_tag++;
        end
    endtask

    task automatic check_status();
        logic [31:0] rdata;
        logic        err;
        apb_read(`ARQ_ADDR_STATUS, rdata, err);
        compare_values("status pslverr", 1'b0, err);
        compare_values("status", predicted_status(), rdata);
    endtask

    task automatic check_config();
        logic [31:0] rdata;
        logic        err;
        apb_read(`ARQ_ADDR_CFG, rdata, err);
        compare_values("config pslverr", 1'b0, err);
        compare_values("config", 32'({model_threshold, model_aging_en}), rdata);
    endtask

    task automatic drain_and_check();
        arq_entry_pkg::arq_item_t item;
        arq_entry_pkg::arq_item_t expected;
        logic                     got;
        while (model_req.size() > 0) begin
            expected.entry.req = model_req.pop_front();
            expected.entry.age = `ARQ_AGE_W'(model_age.pop_front());
            expected.urgent    = expected.entry.age >= model_threshold;
            pop_item(item, got);
            if (got) begin
                compare_values("dispatched item", expected, item);
            end
        end
    endtask

    task automatic check_output_idle();
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_values("out_valid", 1'b0, out_valid);
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        check_status();
        check_config();
        check_output_idle();
    endtask

    task automatic test_order_no_aging();
        test_name = "order_no_aging";
        set_config(1'b0, 8'd4);
        push_random(5);
        drain_and_check();
        check_output_idle();
    endtask

    task automatic test_aging_backpressure();
        test_name = "aging_backpressure";
        set_config(1'b1, 8'hff);
        push_random(6);
        drain_and_check();
    endtask

    task automatic test_full_refused();
        test_name = "full_refused";
        set_config(1'b1, 8'hff);
        push_random(MODEL_CAPACITY);
        check_status();
        // Distinct tag so a leak would show up as a mismatch
        push_request(8'hee, 16'hdead);
        check_status();
        drain_and_check();
        check_status();
        check_output_idle();
    endtask

    task automatic test_urgent_threshold();
        test_name = "urgent_threshold";
        set_config(1'b1, 8'd3);
        push_random(7);
        drain_and_check();
    endtask

    task automatic test_unmapped_access();
        logic [31:0] rdata;
        logic        err;
        test_name = "unmapped_access";
        push_random(3);
        apb_write(12'h00c, 32'hffff_ffff, err);
        compare_values("unmapped write pslverr", 1'b1, err);
        apb_read(12'h010, rdata, err);
        compare_values("unmapped read pslverr", 1'b1, err);
        check_config();
        check_status();
        drain_and_check();
        check_output_idle();
    endtask

    initial begin
        rst       = 1'b1;
        apb_req   = '0;
        out_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_order_no_aging();
        test_aging_backpressure();
        test_full_refused();
        test_urgent_threshold();
        test_unmapped_access();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/arq_apb_pkg.sv
design/arq_entry_pkg.sv
design/apb_request_port.sv
design/age_queue.sv
design/age_tracker.sv
design/dispatch_stage.sv
design/aging_request_queue.sv
tb/tb_aging_request_queue.sv

// File: Bender.yml
package:
  name: aging_request_queue

sources:
  - include_dirs:
      - design
    files:
      - design/arq_apb_pkg.sv
      - design/arq_entry_pkg.sv
      - design/apb_request_port.sv
      - design/age_queue.sv
      - design/age_tracker.sv
      - design/dispatch_stage.sv
      - design/aging_request_queue.sv
      - tb/tb_aging_request_queue.sv
